//--- logic/evr_pkg.sv
package evr_pkg;

    // Bus and link widths
    localparam int MMR_ADDR_W  = 8;
    localparam int MMR_DATA_W  = 32;
    localparam int EV_CODE_W   = 8;
    localparam int LINK_WORD_W = 32;

    // Default event delay line length
    localparam int EV_DELAY_DEPTH_DEF = 16;

    typedef logic [MMR_ADDR_W-1:0] mmr_addr_t;
    typedef logic [MMR_DATA_W-1:0] mmr_data_t;
    typedef logic [EV_CODE_W-1:0]  ev_code_t;

    // Register map, byte addresses
    typedef enum mmr_addr_t {
        SR           = mmr_addr_t'(8'h00),
        CR           = mmr_addr_t'(8'h04),
        CR_S         = mmr_addr_t'(8'h08),
        CR_C         = mmr_addr_t'(8'h0C),
        LINK_TOPO_ID = mmr_addr_t'(8'h10),
        LINK_DELAY   = mmr_addr_t'(8'h14),
        TGT_DELAY    = mmr_addr_t'(8'h18),
        COMP_DELAY   = mmr_addr_t'(8'h1C)
    } evr_reg_e;

    // Special link bytes
    localparam ev_code_t K_COMMA     = 8'hBC;
    localparam ev_code_t BEACON_CODE = 8'h7E;
    localparam ev_code_t NULL_CODE   = 8'h00;

    // Frame type byte following a comma
    typedef enum logic [7:0] {
        FRAME_DELAY = 8'h01,
        FRAME_TOPO  = 8'h02
    } frame_op_e;

    typedef struct packed {
        logic delay_valid;
        logic topo_valid;
        logic frame_err;
    } link_status_t;

    typedef enum logic [1:0] {
        DC_OFF    = 2'd0,
        DC_LOCKED = 2'd1,
        DC_RANGE  = 2'd2
    } dc_status_e;

    // Status register layout, LSB is link_up
    typedef struct packed {
        dc_status_e   dc_status;
        link_status_t link_status;
        logic         link_up;
    } sr_t;

endpackage

//--- logic/evr_link_if.sv
`timescale 1ns/1ps

interface evr_link_if
    import evr_pkg::*;
();

    logic [LINK_WORD_W-1:0] link_delay;
    logic [LINK_WORD_W-1:0] topo_id;
    link_status_t           status;
    // One cycle, on a new link delay value
    logic                   delay_upd;

    modport parser (
        output link_delay,
        output topo_id,
        output status,
        output delay_upd
    );

    modport regs (
        input  link_delay,
        input  topo_id,
        input  status,
        input  delay_upd
    );

endinterface

//--- logic/evr_link_parser.sv
`timescale 1ns/1ps

module evr_link_parser
    import evr_pkg::*;
(
    input  logic              app_clk,
    input  logic              app_rst,
    input  logic              link_up_i,
    input  logic [7:0]        shared_data_i,
    input  logic              shared_isk_i,
    evr_link_if.parser        link
);

    typedef enum logic [1:0] {
        IDLE,
        OPCODE,
        DATA
    } state_e;

    state_e                 state;
    frame_op_e              op;
    logic [1:0]             byte_cnt;
    logic [23:0]            word_sr;
    logic [LINK_WORD_W-1:0] word;
    logic                   is_comma;
    logic                   is_op;

    assign is_comma = shared_isk_i && shared_data_i == K_COMMA;
    assign is_op    = !shared_isk_i &&
                      (shared_data_i == FRAME_DELAY || shared_data_i == FRAME_TOPO);

    // Full word on the cycle of the last data byte
    assign word = {word_sr, shared_data_i};

    always_ff @(posedge app_clk) begin
        if (app_rst || !link_up_i) begin
            state           <= IDLE;
            byte_cnt        <= '0;
            link.link_delay <= '0;
            link.topo_id    <= '0;
            link.status     <= '0;
            link.delay_upd  <= 1'b0;
        end else begin
            link.delay_upd <= 1'b0;

            if (is_comma) begin
                // Comma restarts framing from any state
                state <= OPCODE;
            end else begin
                case (state)
                    OPCODE: begin
                        byte_cnt <= '0;
                        if (is_op) begin
                            state <= DATA;
                        end else begin
                            link.status.frame_err <= 1'b1;
                            state                 <= IDLE;
                        end
                    end
                    DATA: begin
                        if (shared_isk_i) begin
                            link.status.frame_err <= 1'b1;
                            state                 <= IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 2'd1;
                            if (byte_cnt == 2'd3) begin
                                state <= IDLE;
                                if (op == FRAME_DELAY) begin
                                    link.link_delay         <= word;
                                    link.status.delay_valid <= 1'b1;
                                    link.delay_upd          <= (word != link.link_delay);
                                end else begin
                                    link.topo_id           <= word;
                                    link.status.topo_valid <= 1'b1;
                                end
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Frame payload, MSB first
    always_ff @(posedge app_clk) begin
        if (state == OPCODE && is_op) begin
            op <= frame_op_e'(shared_data_i);
        end
        if (state == DATA && !shared_isk_i) begin
            word_sr <= word[23:0];
        end
    end

endmodule

//--- logic/evr_event_decoder.sv
`timescale 1ns/1ps

module evr_event_decoder
    import evr_pkg::*;
#(
    parameter int EV_DELAY_DEPTH = EV_DELAY_DEPTH_DEF
) (
    input  logic                              app_clk,
    input  logic                              app_rst,
    input  logic [7:0]                        ev_data_i,
    input  logic                              ev_isk_i,
    input  logic                              dc_ena_i,
    input  logic [$clog2(EV_DELAY_DEPTH)-1:0] comp_delay_i,
    output ev_code_t                          ev_o,
    output logic                              beacon_o
);

    typedef enum logic [1:0] {
        BYTE_IDLE,
        BYTE_EVENT,
        BYTE_BEACON,
        BYTE_COMMA
    } byte_class_e;

    byte_class_e byte_class;
    ev_code_t    ev_in;
    ev_code_t    ev_line [EV_DELAY_DEPTH];

    // Any K character counts as a comma here
    always_comb begin
        if (ev_isk_i) begin
            byte_class = BYTE_COMMA;
        end else if (ev_data_i == BEACON_CODE) begin
            byte_class = BYTE_BEACON;
        end else if (ev_data_i == NULL_CODE) begin
            byte_class = BYTE_IDLE;
        end else begin
            byte_class = BYTE_EVENT;
        end
    end

    assign ev_in = (byte_class == BYTE_EVENT) ? ev_data_i : NULL_CODE;

    always_ff @(posedge app_clk) begin
        if (app_rst) begin
            beacon_o <= 1'b0;
            for (int i = 0; i < EV_DELAY_DEPTH; i++) begin
                ev_line[i] <= NULL_CODE;
            end
        end else begin
            beacon_o   <= (byte_class == BYTE_BEACON);
            ev_line[0] <= ev_in;
            for (int i = 1; i < EV_DELAY_DEPTH; i++) begin
                ev_line[i] <= ev_line[i-1];
            end
        end
    end

    // Stage k is k+1 cycles behind the input
    assign ev_o = dc_ena_i ? ev_line[comp_delay_i] : ev_line[0];

endmodule

//--- logic/evr_regs.sv
`timescale 1ns/1ps

module evr_regs
    import evr_pkg::*;
#(
    parameter int EV_DELAY_DEPTH = EV_DELAY_DEPTH_DEF
) (
    input  logic                              app_clk,
    input  logic                              app_rst,
    input  logic                              link_up_i,
    evr_link_if.regs                          link,

    input  mmr_addr_t                         awaddr_i,
    input  logic                              awvalid_i,
    output logic                              awready_o,
    input  mmr_data_t                         wdata_i,
    input  logic                              wvalid_i,
    output logic                              wready_o,
    output logic                              bvalid_o,
    input  logic                              bready_i,
    input  mmr_addr_t                         araddr_i,
    input  logic                              arvalid_i,
    output logic                              arready_o,
    output mmr_data_t                         rdata_o,
    output logic                              rvalid_o,
    input  logic                              rready_i,

    output logic                              dc_ena_o,
    output logic [$clog2(EV_DELAY_DEPTH)-1:0] comp_delay_o
);

    localparam int CW = $clog2(EV_DELAY_DEPTH);

    logic          dc_ena;
    logic          dc_range;
    logic [CW-1:0] comp_delay;
    mmr_data_t     tgt_delay;
    mmr_data_t     diff;
    mmr_data_t     rd_mux;
    logic          wr_fire;
    logic          rd_fire;
    logic          tgt_wr;
    logic          wr_accept;
    dc_status_e    dc_status;
    sr_t           sr;

    assign wr_fire   = awready_o && awvalid_i && wvalid_i;
    assign rd_fire   = arready_o && arvalid_i;
    assign wr_accept = awvalid_i && wvalid_i && !bvalid_o && !awready_o;

    // Target must lie beyond the current link delay
    assign tgt_wr = wr_fire && awaddr_i == TGT_DELAY && wdata_i > link.link_delay;

    // Written value takes effect in the same recompute
    assign diff = (tgt_wr ? wdata_i : tgt_delay) - link.link_delay;

    always_comb begin
        if (dc_range) begin
            dc_status = DC_RANGE;
        end else if (dc_ena) begin
            dc_status = DC_LOCKED;
        end else begin
            dc_status = DC_OFF;
        end
    end

    assign sr.dc_status   = dc_status;
    assign sr.link_status = link.status;
    assign sr.link_up     = link_up_i;

    // AXI4-Lite handshake
    always_ff @(posedge app_clk) begin
        if (app_rst) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
            arready_o <= 1'b0;
            rvalid_o  <= 1'b0;
        end else begin
            awready_o <= wr_accept;
            wready_o  <= wr_accept;
            arready_o <= arvalid_i && !rvalid_o && !arready_o;

            if (wr_fire) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end

            if (rd_fire) begin
                rvalid_o <= 1'b1;
            end else if (rready_i) begin
                rvalid_o <= 1'b0;
            end
        end
    end

    always_comb begin
        case (araddr_i)
            SR:           rd_mux = mmr_data_t'(sr);
            CR:           rd_mux = mmr_data_t'(dc_ena);
            LINK_TOPO_ID: rd_mux = mmr_data_t'(link.topo_id);
            LINK_DELAY:   rd_mux = mmr_data_t'(link.link_delay);
            TGT_DELAY:    rd_mux = tgt_delay;
            COMP_DELAY:   rd_mux = mmr_data_t'(comp_delay);
            default:      rd_mux = '0;
        endcase
    end

    // Read data held until rready
    always_ff @(posedge app_clk) begin
        if (rd_fire) begin
            rdata_o <= rd_mux;
        end
    end

    always_ff @(posedge app_clk) begin
        if (app_rst) begin
            dc_ena     <= 1'b0;
            dc_range   <= 1'b0;
            tgt_delay  <= '0;
            comp_delay <= '0;
        end else begin
            if (wr_fire) begin
                case (awaddr_i)
                    CR: begin
                        dc_ena <= wdata_i[0];
                    end
                    CR_S: begin
                        if (wdata_i[0]) begin
                            dc_ena <= 1'b1;
                        end
                    end
                    CR_C: begin
                        if (wdata_i[0]) begin
                            dc_ena <= 1'b0;
                        end
                    end
                    TGT_DELAY: begin
                        if (tgt_wr) begin
                            tgt_delay <= wdata_i;
                        end
                    end
                    default: ;
                endcase
            end

            // Link loss wins over any write
            if (!link_up_i) begin
                dc_ena <= 1'b0;
            end

            // Negative difference wraps and lands out of range too
            if (tgt_wr || link.delay_upd) begin
                if (diff > mmr_data_t'(EV_DELAY_DEPTH - 1)) begin
                    comp_delay <= '0;
                    dc_range   <= 1'b1;
                end else begin
                    comp_delay <= diff[CW-1:0];
                    dc_range   <= 1'b0;
                end
            end
        end
    end

    assign dc_ena_o     = dc_ena;
    assign comp_delay_o = comp_delay;

endmodule

//--- logic/evr_top.sv
`timescale 1ns/1ps

module evr_top
    import evr_pkg::*;
#(
    parameter int EV_DELAY_DEPTH = EV_DELAY_DEPTH_DEF
) (
    input  logic        app_clk,
    input  logic        app_rst,

    input  logic        link_up_i,
    input  logic [15:0] rx_data_i,
    input  logic [1:0]  rx_charisk_i,

    output ev_code_t    ev_o,
    output logic        beacon_o,

    input  mmr_addr_t   awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  mmr_data_t   wdata_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i,
    input  mmr_addr_t   araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output mmr_data_t   rdata_o,
    output logic        rvalid_o,
    input  logic        rready_i
);

    logic                              dc_ena;
    logic [$clog2(EV_DELAY_DEPTH)-1:0] comp_delay;

    evr_link_if link_bus ();

    // Lower byte carries the shared data stream
    evr_link_parser parser_i (
        .app_clk       (app_clk),
        .app_rst       (app_rst),
        .link_up_i     (link_up_i),
        .shared_data_i (rx_data_i[7:0]),
        .shared_isk_i  (rx_charisk_i[0]),
        .link          (link_bus.parser)
    );

    // Upper byte carries events and beacons
    evr_event_decoder #(
        .EV_DELAY_DEPTH (EV_DELAY_DEPTH)
    ) decoder_i (
        .app_clk      (app_clk),
        .app_rst      (app_rst),
        .ev_data_i    (rx_data_i[15:8]),
        .ev_isk_i     (rx_charisk_i[1]),
        .dc_ena_i     (dc_ena),
        .comp_delay_i (comp_delay),
        .ev_o         (ev_o),
        .beacon_o     (beacon_o)
    );

    evr_regs #(
        .EV_DELAY_DEPTH (EV_DELAY_DEPTH)
    ) regs_i (
        .app_clk      (app_clk),
        .app_rst      (app_rst),
        .link_up_i    (link_up_i),
        .link         (link_bus.regs),
        .awaddr_i     (awaddr_i),
        .awvalid_i    (awvalid_i),
        .awready_o    (awready_o),
        .wdata_i      (wdata_i),
        .wvalid_i     (wvalid_i),
        .wready_o     (wready_o),
        .bvalid_o     (bvalid_o),
        .bready_i     (bready_i),
        .araddr_i     (araddr_i),
        .arvalid_i    (arvalid_i),
        .arready_o    (arready_o),
        .rdata_o      (rdata_o),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i),
        .dc_ena_o     (dc_ena),
        .comp_delay_o (comp_delay)
    );

endmodule

//--- sim/evr_properties.sv
`timescale 1ns/1ps

module evr_properties
    import evr_pkg::*;
(
    input logic     app_clk,
    input logic     app_rst,
    input logic     awready_o,
    input logic     wready_o,
    input logic     bvalid_o,
    input logic     bready_i,
    input logic     rvalid_o,
    input logic     rready_i,
    input ev_code_t ev_o,
    input logic     beacon_o
);

    a_bvalid_hold: assert property (@(posedge app_clk) disable iff (app_rst)
        bvalid_o && !bready_i |=> bvalid_o)
        else $error("bvalid_o fell before bready_i");

    a_rvalid_hold: assert property (@(posedge app_clk) disable iff (app_rst)
        rvalid_o && !rready_i |=> rvalid_o)
        else $error("rvalid_o fell before rready_i");

    // No new write accepted while a response waits
    a_no_accept_on_b: assert property (@(posedge app_clk) disable iff (app_rst)
        bvalid_o |-> !awready_o && !wready_o)
        else $error("awready_o or wready_o high with bvalid_o pending");

    a_no_beacon_event: assert property (@(posedge app_clk) disable iff (app_rst)
        ev_o != BEACON_CODE)
        else $error("beacon code seen on ev_o");

    a_quiet_in_reset: assert property (@(posedge app_clk)
        app_rst |=> ev_o == NULL_CODE && !beacon_o)
        else $error("ev_o or beacon_o active during reset");

endmodule

bind evr_top evr_properties props_i (
    .app_clk   (app_clk),
    .app_rst   (app_rst),
    .awready_o (awready_o),
    .wready_o  (wready_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .ev_o      (ev_o),
    .beacon_o  (beacon_o)
);

//--- sim/evr_tb.sv
`timescale 1ns/1ps

module evr_tb
    import evr_pkg::*;
();

    localparam int DEPTH      = EV_DELAY_DEPTH_DEF;
    localparam int RST_CYCLES = 5;
    localparam int HS_LIMIT   = 16;

    typedef enum logic [1:0] {
        STEP_WORD,
        STEP_WRITE,
        STEP_READ,
        STEP_LINK
    } step_kind_e;

    // value is write data or expected read data, data[0] is the link level
    typedef struct packed {
        step_kind_e  kind;
        logic [15:0] data;
        logic [1:0]  isk;
        ev_code_t    exp_ev;
        logic        exp_beacon;
        mmr_addr_t   addr;
        mmr_data_t   value;
        logic [2:0]  hold;
    } step_t;

    logic        app_clk;
    logic        app_rst;
    logic        link_up_i;
    logic [15:0] rx_data_i;
    logic [1:0]  rx_charisk_i;
    ev_code_t    ev_o;
    logic        beacon_o;
    mmr_addr_t   awaddr_i;
    logic        awvalid_i;
    logic        awready_o;
    mmr_data_t   wdata_i;
    logic        wvalid_i;
    logic        wready_o;
    logic        bvalid_o;
    logic        bready_i;
    mmr_addr_t   araddr_i;
    logic        arvalid_i;
    logic        arready_o;
    mmr_data_t   rdata_o;
    logic        rvalid_o;
    logic        rready_i;

    step_t        steps[$];
    ev_code_t     ev_hist[$];
    logic         beacon_prev = 1'b0;
    int           errors      = 0;
    int           wd_cycles   = 0;

    // Expected state of the receiver
    logic         m_link_up   = 1'b0;
    logic         m_dc_ena    = 1'b0;
    logic         m_range     = 1'b0;
    link_status_t m_status    = '0;
    mmr_data_t    m_delay     = '0;
    mmr_data_t    m_topo      = '0;
    mmr_data_t    m_tgt       = '0;
    mmr_data_t    m_comp      = '0;

    evr_top dut0 (.*);

    initial app_clk = 1'b0;
    always #5 app_clk = ~app_clk;

    task automatic stop_with_error(input string msg);
        errors++;
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_ev(input ev_code_t exp, input ev_code_t act);
        if (act !== exp)
            stop_with_error($sformatf("** Error at %0d ns: ev_o expected 0x%02h, actual 0x%02h",
                                      $time, exp, act));
    endtask

    task automatic check_beacon(input logic exp, input logic act);
        if (act !== exp)
            stop_with_error($sformatf("** Error at %0d ns: beacon_o expected %b, actual %b",
                                      $time, exp, act));
    endtask

    task automatic check_reg(input string name, input mmr_data_t exp, input mmr_data_t act);
        if (act !== exp)
            stop_with_error($sformatf("** Error at %0d ns: %s expected 0x%08h, actual 0x%08h",
                                      $time, name, exp, act));
    endtask

    function automatic ev_code_t rand_code();
        logic [31:0] r;
        ev_code_t    code;
        code = NULL_CODE;
        while (code == NULL_CODE || code == BEACON_CODE || code == K_COMMA) begin
            r    = $urandom();
            code = r[7:0];
        end
        return code;
    endfunction

    // Target minus link delay, out of range past the last delay stage
    function automatic void recompute();
        mmr_data_t diff;
        diff = m_tgt - m_delay;
        if (diff > mmr_data_t'(DEPTH - 1)) begin
            m_comp  = '0;
            m_range = 1'b1;
        end else begin
            m_comp  = diff;
            m_range = 1'b0;
        end
    endfunction

    function automatic mmr_data_t reg_value(mmr_addr_t addr);
        sr_t sr;
        if (m_range)
            sr.dc_status = DC_RANGE;
        else if (m_dc_ena)
            sr.dc_status = DC_LOCKED;
        else
            sr.dc_status = DC_OFF;
        sr.link_status = m_status;
        sr.link_up     = m_link_up;
        case (addr)
            SR:           return mmr_data_t'(sr);
            CR:           return mmr_data_t'(m_dc_ena);
            LINK_TOPO_ID: return m_topo;
            LINK_DELAY:   return m_delay;
            TGT_DELAY:    return m_tgt;
            COMP_DELAY:   return m_comp;
            default:      return '0;
        endcase
    endfunction

    function automatic void add_step(step_kind_e kind, logic [15:0] data, logic [1:0] isk,
                                     mmr_addr_t addr, mmr_data_t value, logic [2:0] hold);
        step_t s;
        int    lat;
        lat          = m_dc_ena ? 1 + int'(m_comp) : 1;
        s.kind       = kind;
        s.data       = data;
        s.isk        = isk;
        s.addr       = addr;
        s.value      = value;
        s.hold       = hold;
        s.exp_ev     = (ev_hist.size() >= lat) ? ev_hist[ev_hist.size() - lat] : NULL_CODE;
        s.exp_beacon = beacon_prev;
        steps.push_back(s);
        if (kind == STEP_WORD) begin
            if (isk[1] || data[15:8] == BEACON_CODE)
                ev_hist.push_back(NULL_CODE);
            else
                ev_hist.push_back(data[15:8]);
            beacon_prev = !isk[1] && data[15:8] == BEACON_CODE;
        end else begin
            // Upper byte idles during bus steps, line is drained beforehand
            ev_hist.delete();
            beacon_prev = 1'b0;
        end
    endfunction

    function automatic void add_word(logic [15:0] data, logic [1:0] isk);
        add_step(STEP_WORD, data, isk, '0, '0, '0);
    endfunction

    function automatic void add_idle(int n);
        for (int i = 0; i < n; i++)
            add_word(16'h0000, 2'b00);
    endfunction

    function automatic void add_read(mmr_addr_t addr, logic [2:0] hold);
        add_step(STEP_READ, 16'h0000, 2'b00, addr, reg_value(addr), hold);
    endfunction

    function automatic void add_write(mmr_addr_t addr, mmr_data_t value);
        add_step(STEP_WRITE, 16'h0000, 2'b00, addr, value, '0);
        case (addr)
            CR:   m_dc_ena = value[0];
            CR_S: m_dc_ena = m_dc_ena | value[0];
            CR_C: m_dc_ena = m_dc_ena & ~value[0];
            TGT_DELAY: begin
                if (value > m_delay) begin
                    m_tgt = value;
                    recompute();
                end
            end
            default: ;
        endcase
        if (!m_link_up)
            m_dc_ena = 1'b0;
    endfunction

    function automatic void add_link(logic up);
        add_step(STEP_LINK, {15'd0, up}, 2'b00, '0, '0, '0);
        m_link_up = up;
        if (!up) begin
            m_dc_ena = 1'b0;
            m_status = '0;
            m_delay  = '0;
            m_topo   = '0;
        end
    endfunction

    // Comma, opcode, four bytes MSB first, bad puts a K flag on the third
    function automatic void add_frame(frame_op_e op, mmr_data_t word, logic bad);
        add_word({NULL_CODE, K_COMMA}, 2'b01);
        add_word({NULL_CODE, op}, 2'b00);
        for (int i = 3; i >= 0; i--) begin
            if (bad && i == 1)
                add_word({NULL_CODE, 8'h1C}, 2'b01);
            else
                add_word({NULL_CODE, word[8*i +: 8]}, 2'b00);
        end
        if (bad) begin
            m_status.frame_err = 1'b1;
        end else if (op == FRAME_DELAY) begin
            m_status.delay_valid = 1'b1;
            if (word != m_delay) begin
                m_delay = word;
                recompute();
            end
        end else begin
            m_status.topo_valid = 1'b1;
            m_topo              = word;
        end
    endfunction

    // Events back to back, with beacons, commas and nulls mixed in
    function automatic void add_events(int n);
        for (int i = 0; i < n; i++) begin
            case (i % 6)
                4:       add_word({BEACON_CODE, NULL_CODE}, 2'b00);
                5:       add_word((i % 12 == 5) ? {K_COMMA, NULL_CODE} : 16'h0000,
                                  (i % 12 == 5) ? 2'b10 : 2'b00);
                default: add_word({rand_code(), NULL_CODE}, 2'b00);
            endcase
        end
        add_idle(DEPTH + 1);
    endfunction

    function automatic void build_table();
        add_read(SR, 0);
        add_read(LINK_DELAY, 0);
        add_read(TGT_DELAY, 0);
        add_read(COMP_DELAY, 0);
        add_link(1'b1);
        add_read(SR, 0);
        add_frame(FRAME_DELAY, 32'h0000_0123, 1'b0);
        add_frame(FRAME_TOPO, 32'h5a3c_0fbc, 1'b0);
        add_read(LINK_DELAY, 0);
        add_read(LINK_TOPO_ID, 0);
        add_read(SR, 0);
        add_frame(FRAME_DELAY, 32'h0000_0456, 1'b1);
        add_read(LINK_DELAY, 0);
        add_read(LINK_TOPO_ID, 0);
        add_read(SR, 0);
        add_events(30);
        add_write(TGT_DELAY, m_delay + 5);
        add_write(CR_S, 32'h1);
        add_read(COMP_DELAY, 0);
        add_read(SR, 0);
        add_events(24);
        add_write(CR_C, 32'h1);
        add_read(CR, 0);
        add_events(12);
        add_write(TGT_DELAY, m_delay);
        add_read(TGT_DELAY, 0);
        add_write(CR, 32'h1);
        add_write(TGT_DELAY, m_delay + DEPTH + 4);
        add_read(COMP_DELAY, 0);
        add_read(SR, 0);
        add_events(12);
        add_link(1'b0);
        add_read(SR, 0);
        add_read(CR, 0);
        add_link(1'b1);
        add_read(TGT_DELAY, 4);
        add_read(8'h20, 0);
    endfunction

    function automatic logic hs_level(int sel);
        case (sel)
            0:       return awready_o && wready_o;
            1:       return bvalid_o;
            2:       return arready_o;
            default: return rvalid_o;
        endcase
    endfunction

    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        while (!hs_level(sel)) begin
            @(posedge app_clk);
            #1;
            n++;
            if (n > HS_LIMIT)
                stop_with_error($sformatf("Error: %s did not rise within %0d cycles",
                                          what, HS_LIMIT));
        end
    endtask

    // Outputs here still show the previous word
    task automatic apply_word(input step_t s);
        check_ev(s.exp_ev, ev_o);
        check_beacon(s.exp_beacon, beacon_o);
        rx_data_i    = s.data;
        rx_charisk_i = s.isk;
    endtask

    task automatic apply_write(input step_t s);
        awaddr_i  = s.addr;
        wdata_i   = s.value;
        awvalid_i = 1'b1;
        wvalid_i  = 1'b1;
        wait_for(0, "awready_o and wready_o");
        @(posedge app_clk);
        #1;
        awvalid_i = 1'b0;
        wvalid_i  = 1'b0;
        wait_for(1, "bvalid_o");
        // Response waits one cycle for bready
        @(posedge app_clk);
        #1;
        if (!bvalid_o)
            stop_with_error("Error: bvalid_o fell while bready_i was held low");
        bready_i = 1'b1;
        @(posedge app_clk);
        #1;
        bready_i = 1'b0;
    endtask

    task automatic apply_read(input step_t s);
        araddr_i  = s.addr;
        arvalid_i = 1'b1;
        wait_for(2, "arready_o");
        @(posedge app_clk);
        #1;
        arvalid_i = 1'b0;
        // Address may move once accepted
        araddr_i  = ~s.addr;
        wait_for(3, "rvalid_o");
        check_reg("rdata_o", s.value, rdata_o);
        // Response must sit still while rready is low
        repeat (s.hold) begin
            @(posedge app_clk);
            #1;
            if (!rvalid_o)
                stop_with_error("Error: rvalid_o fell while rready_i was held low");
            check_reg("rdata_o", s.value, rdata_o);
        end
        rready_i = 1'b1;
        @(posedge app_clk);
        #1;
        rready_i = 1'b0;
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge app_clk);
        stop_with_error("Error: watchdog expired before the step table was done");
    end

    initial begin
        app_rst      = 1'b1;
        link_up_i    = 1'b0;
        rx_data_i    = '0;
        rx_charisk_i = '0;
        awaddr_i     = '0;
        awvalid_i    = 1'b0;
        wdata_i      = '0;
        wvalid_i     = 1'b0;
        bready_i     = 1'b0;
        araddr_i     = '0;
        arvalid_i    = 1'b0;
        rready_i     = 1'b0;
        void'($urandom(32'hee91_702a));
        build_table();
        wd_cycles = steps.size() * 20 + RST_CYCLES;
        repeat (RST_CYCLES) @(posedge app_clk);
        #1;
        app_rst = 1'b0;
        foreach (steps[i]) begin
            @(posedge app_clk);
            #1;
            rx_data_i    = '0;
            rx_charisk_i = '0;
            case (steps[i].kind)
                STEP_WORD:  apply_word(steps[i]);
                STEP_WRITE: apply_write(steps[i]);
                STEP_READ:  apply_read(steps[i]);
                default:    link_up_i = steps[i].data[0];
            endcase
        end
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- evr.f
logic/evr_pkg.sv
logic/evr_link_if.sv
logic/evr_link_parser.sv
logic/evr_event_decoder.sv
logic/evr_regs.sv
logic/evr_top.sv
sim/evr_properties.sv
sim/evr_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f evr.f --top-module evr_tb -o evr_sim
./obj_dir/evr_sim > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
